/* include/issue_queue_settings.svh */
`ifndef ISSUE_QUEUE_SETTINGS_SVH
`define ISSUE_QUEUE_SETTINGS_SVH

// Number of functional-unit queues
`define ISSUE_NUM_UNITS 4

// Entries held per unit queue
`define ISSUE_FIFO_DEPTH 4

// Operation tag width in bits
`define ISSUE_TAG_WIDTH 6

// Operand width in bits
`define ISSUE_OPERAND_WIDTH 32

`endif

/* src/issue_types_pkg.sv */
`include "issue_queue_settings.svh"

package issue_types_pkg;

    // Functional unit number
    typedef logic [$clog2(`ISSUE_NUM_UNITS)-1:0] unit_id_t;

    // Operation tag, returned with the result
    typedef logic [`ISSUE_TAG_WIDTH-1:0] tag_t;

    // Single operand value
    typedef logic [`ISSUE_OPERAND_WIDTH-1:0] operand_t;

    // Request on the issue port
    typedef struct packed {
        unit_id_t unit_id;
        tag_t     tag;
        operand_t operand;
    } issue_req_t;

    // Packet on the writeback port
    typedef struct packed {
        unit_id_t unit_id;
        tag_t     tag;
        operand_t operand;
    } wb_packet_t;

endpackage

/* src/queue_types_pkg.sv */
`include "issue_queue_settings.svh"

package queue_types_pkg;

    // One bit per unit queue
    typedef logic [`ISSUE_NUM_UNITS-1:0] unit_mask_t;

    // Index and occupancy at the configured queue depth
    typedef logic [$clog2(`ISSUE_FIFO_DEPTH)-1:0] fifo_index_t;
    typedef logic [$clog2(`ISSUE_FIFO_DEPTH):0] fifo_count_t;

    // Accepted requests per unit, wraps
    typedef logic [15:0] req_count_t;

    // Unit id is implied by the queue, so only tag and operand are stored
    typedef struct packed {
        issue_types_pkg::tag_t     tag;
        issue_types_pkg::operand_t operand;
    } queue_entry_t;

    // Writeback arbiter states
    typedef enum logic {
        ARB_SCAN,
        ARB_HOLD
    } arb_state_t;

endpackage

/* src/lfsr.sv */
module lfsr #(
    parameter int WIDTH = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             en,
    output logic [WIDTH-1:0] value
);

    // Feedback taps per width, bit n-1 is the shifted-out bit
    function automatic logic [7:0] tap_mask(input int w);
        case (w)
            2: return 8'b0000_0011;
            3: return 8'b0000_0110;
            4: return 8'b0000_1100;
            5: return 8'b0001_0100;
            6: return 8'b0011_0000;
            7: return 8'b0110_0000;
            default: return 8'b1011_1000;
        endcase
    endfunction

    localparam logic [WIDTH-1:0] TAPS = WIDTH'(tap_mask(WIDTH));

    logic [WIDTH-1:0] next_value;

    generate if (WIDTH == 1) begin : gen_toggle
        // Two states only
        assign next_value = ~value;
    end else begin : gen_shift
        // Extra term splices the all-zero state into the sequence
        // so every WIDTH-bit value is visited once per period
        assign next_value = {value[WIDTH-2:0],
                             (^(value & TAPS)) ^ ~|value[WIDTH-2:0]};
    end endgenerate

    // Seed is zero
    always_ff @(posedge clk) begin
        if (rst) begin
            value <= '0;
        end else if (en) begin
            value <= next_value;
        end
    end

endmodule

/* src/lutram_1w_1r.sv */
module lutram_1w_1r #(
    parameter int DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         ram_write,
    input  logic [$clog2(DEPTH)-1:0]     waddr,
    input  logic [$clog2(DEPTH)-1:0]     raddr,
    input  queue_types_pkg::queue_entry_t new_ram_data,
    output queue_types_pkg::queue_entry_t ram_data_out
);
    import queue_types_pkg::*;

    // Distributed RAM array
    queue_entry_t ram [DEPTH];

    // Synchronous write port
    always_ff @(posedge clk) begin
        if (ram_write) begin
            ram[waddr] <= new_ram_data;
        end
    end

    // Asynchronous read port
    assign ram_data_out = ram[raddr];

endmodule

/* src/unit_fifo.sv */
module unit_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          push,
    input  logic                          pop,
    input  queue_types_pkg::queue_entry_t data_in,
    output logic                          valid,
    output logic                          full,
    output queue_types_pkg::queue_entry_t data_out
);
    import queue_types_pkg::*;

    localparam int LOG2_DEPTH = $clog2(DEPTH);

    // No overflow or underflow protection here
    // Router and arbiter keep push and pop legal

    generate if (DEPTH == 1) begin : gen_depth_one
        ////////////////////
        // Single register
        always_ff @(posedge clk) begin
            if (rst) begin
                valid <= 1'b0;
            end else if (push & ~pop) begin
                valid <= 1'b1;
            end else if (pop & ~push) begin
                valid <= 1'b0;
            end
        end

        assign full = valid;

        always_ff @(posedge clk) begin
            if (push) begin
                data_out <= data_in;
            end
        end
    end else if (DEPTH == 2) begin : gen_depth_two
        ////////////////////
        // Two-entry shift register
        typedef logic [LOG2_DEPTH:0] count_t;

        queue_entry_t shift_reg [2];
        count_t       inflight_count;

        // Counts down on push, up on pop, top bit set while occupied
        always_ff @(posedge clk) begin
            if (rst) begin
                inflight_count <= '0;
            end else begin
                inflight_count <= inflight_count + count_t'(pop) - count_t'(push);
            end
        end

        assign valid = inflight_count[LOG2_DEPTH];
        assign full  = valid & ~|inflight_count[LOG2_DEPTH-1:0];

        // Newest entry always lands in slot 0
        always_ff @(posedge clk) begin
            if (push) begin
                shift_reg[0] <= data_in;
                shift_reg[1] <= shift_reg[0];
            end
        end

        // Odd count means one entry, in slot 0
        assign data_out = shift_reg[~inflight_count[0]];
    end else begin : gen_depth_3_plus
        ////////////////////
        // LFSR-indexed RAM
        typedef logic [LOG2_DEPTH:0]   count_t;
        typedef logic [LOG2_DEPTH-1:0] index_t;

        index_t write_index;
        index_t read_index;
        count_t inflight_count;

        always_ff @(posedge clk) begin
            if (rst) begin
                inflight_count <= '0;
            end else begin
                inflight_count <= inflight_count + count_t'(pop) - count_t'(push);
            end
        end

        assign valid = inflight_count[LOG2_DEPTH];
        assign full  = inflight_count == count_t'(-DEPTH);

        // Both pointers walk the same sequence, no adder needed
        lfsr #(.WIDTH(LOG2_DEPTH)) lfsr_read_index (
            .clk   (clk),
            .rst   (rst),
            .en    (pop),
            .value (read_index)
        );

        lfsr #(.WIDTH(LOG2_DEPTH)) lfsr_write_index (
            .clk   (clk),
            .rst   (rst),
            .en    (push),
            .value (write_index)
        );

        // Storage rounded up to a power of two
        lutram_1w_1r #(.DEPTH(2 ** LOG2_DEPTH)) storage (
            .clk          (clk),
            .ram_write    (push),
            .waddr        (write_index),
            .raddr        (read_index),
            .new_ram_data (data_in),
            .ram_data_out (data_out)
        );
    end endgenerate

endmodule

/* src/issue_router.sv */
`include "issue_queue_settings.svh"

module issue_router (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  issue_types_pkg::issue_req_t   in_req,
    input  queue_types_pkg::unit_mask_t   fifo_full,
    output queue_types_pkg::unit_mask_t   push,
    output queue_types_pkg::queue_entry_t entry
);
    import queue_types_pkg::*;

    unit_mask_t target;
    req_count_t accepted_count [`ISSUE_NUM_UNITS];

    // One-hot target unit
    assign target = unit_mask_t'(1) << in_req.unit_id;

    // Ready follows only the target queue, a same-cycle pop is ignored
    assign in_ready = ~|(target & fifo_full);

    // Push only on a transfer
    assign push = target & {`ISSUE_NUM_UNITS{in_valid & in_ready}};

    // Unit id is dropped, the queue index carries it
    assign entry.tag     = in_req.tag;
    assign entry.operand = in_req.operand;

    ////////////////////
    // Accepted requests per unit
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < `ISSUE_NUM_UNITS; k++) begin
                accepted_count[k] <= '0;
            end
        end else begin
            for (int k = 0; k < `ISSUE_NUM_UNITS; k++) begin
                if (push[k]) begin
                    accepted_count[k] <= accepted_count[k] + 1'b1;
                end
            end
        end
    end

endmodule

/* src/writeback_arbiter.sv */
`include "issue_queue_settings.svh"

module writeback_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  queue_types_pkg::unit_mask_t   fifo_valid,
    input  queue_types_pkg::queue_entry_t fifo_data [`ISSUE_NUM_UNITS],
    output queue_types_pkg::unit_mask_t   pop,
    output logic                          out_valid,
    input  logic                          out_ready,
    output issue_types_pkg::wb_packet_t   out_pkt
);
    import issue_types_pkg::*;
    import queue_types_pkg::*;

    localparam int NUM_UNITS = `ISSUE_NUM_UNITS;

    arb_state_t state;
    unit_id_t   rr_ptr;
    unit_id_t   hold_grant;
    unit_id_t   scan_grant;
    logic       scan_found;
    unit_id_t   grant;
    logic       transfer;

    ////////////////////
    // Round-robin scan
    // First valid queue at or after the pointer
    always_comb begin
        int idx;
        scan_found = 1'b0;
        scan_grant = rr_ptr;
        for (int i = 0; i < NUM_UNITS; i++) begin
            idx = (int'(rr_ptr) + i) % NUM_UNITS;
            if (!scan_found && fifo_valid[idx]) begin
                scan_found = 1'b1;
                scan_grant = unit_id_t'(idx);
            end
        end
    end

    // Stalled grant stays latched until it transfers
    assign grant     = (state == ARB_HOLD) ? hold_grant : scan_grant;
    assign out_valid = (state == ARB_HOLD) | scan_found;
    assign transfer  = out_valid & out_ready;

    // At most one pop, only for the granted queue
    assign pop = transfer ? (unit_mask_t'(1) << grant) : '0;

    // Output packet from grant number and queue head
    assign out_pkt.unit_id = grant;
    assign out_pkt.tag     = fifo_data[grant].tag;
    assign out_pkt.operand = fifo_data[grant].operand;

    ////////////////////
    // FSM and pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ARB_SCAN;
            rr_ptr     <= '0;
            hold_grant <= '0;
        end else begin
            if (transfer) begin
                state <= ARB_SCAN;
                // Next search starts one past the winner
                if (grant == unit_id_t'(NUM_UNITS - 1)) begin
                    rr_ptr <= '0;
                end else begin
                    rr_ptr <= grant + 1'b1;
                end
            end else if (out_valid) begin
                // Output stalled
                state      <= ARB_HOLD;
                hold_grant <= grant;
            end
        end
    end

endmodule

/* src/issue_queue_top.sv */
`include "issue_queue_settings.svh"

module issue_queue_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  issue_types_pkg::issue_req_t in_req,
    output logic                        out_valid,
    input  logic                        out_ready,
    output issue_types_pkg::wb_packet_t out_pkt
);
    import queue_types_pkg::*;

    unit_mask_t   push;
    unit_mask_t   pop;
    unit_mask_t   fifo_valid;
    unit_mask_t   fifo_full;
    queue_entry_t entry;
    queue_entry_t fifo_data [`ISSUE_NUM_UNITS];

    ////////////////////
    // Issue side
    issue_router router (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .fifo_full (fifo_full),
        .push      (push),
        .entry     (entry)
    );

    // One queue per functional unit, shared write data
    generate for (genvar k = 0; k < `ISSUE_NUM_UNITS; k++) begin : gen_unit
        unit_fifo #(.DEPTH(`ISSUE_FIFO_DEPTH)) fifo (
            .clk      (clk),
            .rst      (rst),
            .push     (push[k]),
            .pop      (pop[k]),
            .data_in  (entry),
            .valid    (fifo_valid[k]),
            .full     (fifo_full[k]),
            .data_out (fifo_data[k])
        );
    end endgenerate

    ////////////////////
    // Writeback side
    writeback_arbiter arbiter (
        .clk        (clk),
        .rst        (rst),
        .fifo_valid (fifo_valid),
        .fifo_data  (fifo_data),
        .pop        (pop),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_pkt    (out_pkt)
    );

endmodule

/* tests/issue_queue_assert.sv */
`include "issue_queue_settings.svh"

module issue_queue_assert (
    input logic                        clk,
    input logic                        rst,
    input queue_types_pkg::unit_mask_t push,
    input queue_types_pkg::unit_mask_t pop,
    input queue_types_pkg::unit_mask_t fifo_valid,
    input queue_types_pkg::req_count_t accepted_count [`ISSUE_NUM_UNITS],
    input logic                        out_valid,
    input logic                        out_ready,
    input issue_types_pkg::wb_packet_t out_pkt
);
    timeunit 1ns;
    timeprecision 1ps;

    import queue_types_pkg::*;

    // Pops per unit, wrapping like the router's accepted count
    req_count_t popped_count [`ISSUE_NUM_UNITS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < `ISSUE_NUM_UNITS; k++) begin
                popped_count[k] <= '0;
            end
        end else begin
            for (int k = 0; k < `ISSUE_NUM_UNITS; k++) begin
                if (pop[k]) begin
                    popped_count[k] <= popped_count[k] + 1'b1;
                end
            end
        end
    end

    generate for (genvar k = 0; k < `ISSUE_NUM_UNITS; k++) begin : gen_unit
        // Router holds off a full queue
        // Occupancy from accepted and popped counts stays below depth on a push
        no_push_when_full: assert property (@(posedge clk) disable iff (rst)
            push[k] |-> req_count_t'(accepted_count[k] - popped_count[k])
                        < req_count_t'(`ISSUE_FIFO_DEPTH))
            else $error("Push into a full unit queue");
    end endgenerate

    // Arbiter pops only a queue with data
    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst)
        ~|(pop & ~fifo_valid))
        else $error("Pop from an empty unit queue");

    // Stalled output keeps valid and payload
    out_pkt_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_pkt))
        else $error("Output packet changed while stalled");

endmodule

bind issue_queue_top issue_queue_assert checks (
    .clk            (clk),
    .rst            (rst),
    .push           (push),
    .pop            (pop),
    .fifo_valid     (fifo_valid),
    .accepted_count (router.accepted_count),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_pkt        (out_pkt)
);

/* tests/issue_queue_tb.sv */
`include "issue_queue_settings.svh"

module issue_queue_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import issue_types_pkg::*;
    import queue_types_pkg::*;

    localparam int NUM_UNITS      = `ISSUE_NUM_UNITS;
    localparam int FIFO_DEPTH     = `ISSUE_FIFO_DEPTH;
    localparam int NUM_REQUESTS   = 2000;
    localparam int TIMEOUT_CYCLES = 20 * NUM_REQUESTS;
    localparam logic [31:0] SEED  = 32'hc719_84cc;

    logic       clk;
    logic       rst;
    logic       in_valid;
    logic       in_ready;
    issue_req_t in_req;
    logic       out_valid;
    logic       out_ready;
    wb_packet_t out_pkt;

    // Reference model with one queue per unit
    queue_entry_t model_q [NUM_UNITS][$];
    int           model_ptr;
    logic         stalled;
    wb_packet_t   held_pkt;

    // Expected values for the current cycle
    logic       exp_ready;
    logic       exp_valid;
    wb_packet_t exp_pkt;

    // Request blocked last cycle keeps its payload
    logic        in_hold;
    int          accepted;
    int          delivered = 0;
    int          cycle_count = 0;
    logic [31:0] rand_state;

    issue_queue_top dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pkt   (out_pkt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // Cycle limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: no finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    // Transfers seen on the output port
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            delivered <= delivered + 1;
        end
    end

    // 32-bit xorshift step
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic compare(input logic [63:0] actual, input logic [63:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "Stopped at the first error");
        end
    endtask

    // First unit from the model pointer with a waiting entry
    // Returns -1 when every model queue is empty
    function automatic int first_waiting_unit();
        int idx;
        int found;
        found = -1;
        for (int i = 0; i < NUM_UNITS; i++) begin
            idx = (model_ptr + i) % NUM_UNITS;
            if (found < 0 && model_q[idx].size() != 0) begin
                found = idx;
            end
        end
        return found;
    endfunction

    ////////////////////
    // Stimulus
    task automatic drive_random();
        logic [31:0] r;
        logic [3:0]  ready_level;
        issue_req_t  req;
        // Slow drain phases fill the queues, fast ones empty them
        ready_level = ((cycle_count / 128) % 2 == 0) ? 4'd6 : 4'd14;
        rand_state  = xorshift32(rand_state);
        r           = rand_state;
        if (!in_hold) begin
            req.unit_id = unit_id_t'(r % NUM_UNITS);
            req.tag     = tag_t'(r >> 8);
            rand_state  = xorshift32(rand_state);
            req.operand = operand_t'(rand_state);
            in_valid   <= (r[17:16] != 2'b00);
            in_req     <= req;
        end
        out_ready <= (r[23:20] < ready_level);
    endtask

    ////////////////////
    // Checks against the model state of the previous edge
    task automatic check_outputs();
        int unit;
        exp_ready = model_q[in_req.unit_id].size() < FIFO_DEPTH;
        compare(64'(in_ready), 64'(exp_ready), "in_ready for requested unit");
        unit      = first_waiting_unit();
        exp_valid = stalled || (unit >= 0);
        compare(64'(out_valid), 64'(exp_valid), "out_valid");
        if (exp_valid) begin
            if (stalled) begin
                // Stalled packet repeats unchanged
                exp_pkt = held_pkt;
            end else begin
                exp_pkt.unit_id = unit_id_t'(unit);
                exp_pkt.tag     = model_q[unit][0].tag;
                exp_pkt.operand = model_q[unit][0].operand;
            end
            compare(64'(out_pkt), 64'(exp_pkt), "out_pkt");
        end
    endtask

    // Transfers that happen at the coming edge
    task automatic update_model();
        queue_entry_t ent;
        if (exp_valid && out_ready) begin
            model_q[exp_pkt.unit_id].delete(0);
            model_ptr = (int'(exp_pkt.unit_id) + 1) % NUM_UNITS;
            stalled   = 1'b0;
        end else if (exp_valid) begin
            stalled  = 1'b1;
            held_pkt = exp_pkt;
        end
        if (in_valid && exp_ready) begin
            ent.tag     = in_req.tag;
            ent.operand = in_req.operand;
            model_q[in_req.unit_id].push_back(ent);
            accepted++;
        end
        in_hold = in_valid && !exp_ready;
    endtask

    function automatic logic model_empty();
        logic empty;
        empty = 1'b1;
        for (int k = 0; k < NUM_UNITS; k++) begin
            if (model_q[k].size() != 0) begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    ////////////////////
    // Main sequence
    initial begin
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_req     = '0;
        out_ready  = 1'b0;
        rand_state = SEED;
        model_ptr  = 0;
        stalled    = 1'b0;
        held_pkt   = '0;
        exp_pkt    = '0;
        in_hold    = 1'b0;
        accepted   = 0;

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Idle state straight after reset
        @(negedge clk);
        compare(64'(out_valid), 64'(1'b0), "out_valid after reset");
        compare(64'(in_ready), 64'(1'b1), "in_ready after reset");

        // Random traffic until every request is in
        while (accepted < NUM_REQUESTS) begin
            @(posedge clk);
            drive_random();
            @(negedge clk);
            check_outputs();
            update_model();
        end

        // Drain with the output always ready
        while (!model_empty() || stalled) begin
            @(posedge clk);
            in_valid  <= 1'b0;
            out_ready <= 1'b1;
            @(negedge clk);
            check_outputs();
            update_model();
        end

        @(posedge clk);
        @(negedge clk);
        compare(64'(out_valid), 64'(1'b0), "out_valid after drain");
        compare(64'(delivered), 64'(accepted), "output count");

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* issue_queue_top.f */
+incdir+include
src/issue_types_pkg.sv
src/queue_types_pkg.sv
src/lfsr.sv
src/lutram_1w_1r.sv
src/unit_fifo.sv
src/issue_router.sv
src/writeback_arbiter.sv
src/issue_queue_top.sv
tests/issue_queue_assert.sv
tests/issue_queue_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= issue_queue_tb
FILELIST  ?= issue_queue_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, search the log for the pass line"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
